//--- project.f
+incdir+hdl
hdl/serial_pkg.sv
hdl/board_pkg.sv
hdl/uart_receiver.sv
hdl/byte_fifo.sv
hdl/uart_transmitter.sv
hdl/board_top.sv
bench/tb_board_top.sv

//--- Bender.yml
package:
  name: serial_echo

export_include_dirs:
  - hdl

sources:
  - hdl/serial_pkg.sv
  - hdl/board_pkg.sv
  - hdl/uart_receiver.sv
  - hdl/byte_fifo.sv
  - hdl/uart_transmitter.sv
  - hdl/board_top.sv

  - target: test
    files:
      - bench/tb_board_top.sv

//--- bench/tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module tb_board_top;

    localparam int clk_period   = 100;
    localparam int clks_per_bit = `UART_CLKS_PER_BIT;
    localparam int half_bit     = clks_per_bit / 2;
    localparam int frame_cycles = 10 * clks_per_bit;
    localparam int key_reset    = `W_KEY - 1;
    localparam int n_echo       = 8;
    localparam int n_swap       = 9;
    localparam int n_burst      = `FIFO_DEPTH;
    localparam int n_long       = 440;
    // Every frame counts twice as it goes out on RX and returns on TX
    localparam int total_frames = 2 * (n_echo + n_swap + n_burst + n_long + 1);
    localparam longint watchdog_ns =
        longint'(total_frames + 40) * frame_cycles * clk_period;

    logic                clk = 1'b0;
    logic [`W_KEY - 1:0] KEY;
    logic                UART_RX;
    logic                UART_TX;
    logic [`W_LED - 1:0] LED;

    logic [7:0]  echo_q [$];           // Bytes decoded from UART_TX
    logic [31:0] rng_state = 32'd83908;
    int          errors    = 0;
    int          checks    = 0;

    board_top u_dut
    (
        .CLK     ( clk     ),
        .KEY     ( KEY     ),
        .UART_RX ( UART_RX ),
        .UART_TX ( UART_TX ),
        .LED     ( LED     )
    );

    always #(clk_period / 2) clk = ~clk;

    //------------------------------------------------------------

    function automatic logic [31:0] xorshift32 (input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Upper and lower case ASCII letters are 32 codes apart
    function automatic logic [7:0] toggled_case (input logic [7:0] c);
        if (c >= 8'h41 && c <= 8'h5a)
            return c + 8'd32;
        else if (c >= 8'h61 && c <= 8'h7a)
            return c - 8'd32;
        else
            return c;
    endfunction

    function automatic logic [31:0] echo_at (input int idx);
        if (idx < echo_q.size())
            return {24'h0, echo_q[idx]};
        else
            return 32'hdead;  // A missing byte never matches
    endfunction

    task automatic check_value (input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic drive_bit (input logic b, input int cycles);
        UART_RX <= b;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic send_byte (input logic [7:0] data, input logic bad_stop,
                              input int stop_cycles);
        int i;
        drive_bit(1'b0, clks_per_bit);  // Start bit
        for (i = 0; i < 8; i++)
            drive_bit(data[i], clks_per_bit);
        drive_bit(~bad_stop, stop_cycles);
        if (bad_stop)
            drive_bit(1'b1, clks_per_bit);  // Back to idle
    endtask

    task automatic wait_echoes (input int n);
        int limit;
        int cycles;
        limit  = (n + 2) * frame_cycles;
        cycles = 0;
        while (echo_q.size() < n && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (echo_q.size() < n)
        begin
            $display("Timed out waiting for %0d echoed bytes, only %0d arrived",
                     n, echo_q.size());
            errors++;
        end
    endtask

    // Returns once no echo has arrived for three frame times
    task automatic wait_drain ();
        int last;
        int idle;
        last = echo_q.size();
        idle = 0;
        while (idle < 3 * frame_cycles)
        begin
            @(posedge clk);
            if (echo_q.size() != last)
            begin
                last = echo_q.size();
                idle = 0;
            end
            else
                idle++;
        end
    endtask

    task automatic apply_reset ();
        @(posedge clk);
        KEY[key_reset] <= 1'b0;  // Reset key pressed
        repeat (16) @(posedge clk);
        KEY[key_reset] <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    //------------------------------------------------------------

    task automatic check_idle_after_reset ();
        apply_reset();
        check_value("UART_TX", UART_TX, 1'b1);
        check_value("LED", LED, 6'h3f);
    endtask

    task automatic echo_single_bytes ();
        logic [7:0] sent;
        int         i;
        echo_q.delete();
        KEY[0] <= 1'b1;
        for (i = 0; i < n_echo; i++)
        begin
            rng_state = xorshift32(rng_state);
            sent      = rng_state[7:0];
            send_byte(sent, 1'b0, clks_per_bit);
            wait_echoes(i + 1);
            check_value("echoed byte", echo_at(i), sent);
        end
        check_value("fill LED pins", LED[3:0], 4'hf);
    endtask

    task automatic echo_with_case_swap ();
        logic [7:0] chars [n_swap];
        int         i;
        chars = '{8'h40, 8'h41, 8'h5a, 8'h5b, 8'h60, 8'h61, 8'h7a, 8'h7b, 8'h35};
        echo_q.delete();
        KEY[0] <= 1'b0;  // Case swap key held
        for (i = 0; i < n_swap; i++)
        begin
            send_byte(chars[i], 1'b0, clks_per_bit);
            wait_echoes(i + 1);
            check_value("swapped byte", echo_at(i), toggled_case(chars[i]));
        end
        KEY[0] <= 1'b1;
    endtask

    task automatic echo_burst ();
        logic [7:0] sent [n_burst];
        int         i;
        echo_q.delete();
        for (i = 0; i < n_burst; i++)
        begin
            rng_state = xorshift32(rng_state);
            sent[i]   = rng_state[7:0];
            send_byte(sent[i], 1'b0, clks_per_bit);
        end
        wait_echoes(n_burst);
        for (i = 0; i < n_burst; i++)
            check_value("burst byte", echo_at(i), sent[i]);
        check_value("overflow LED pin", LED[5], 1'b1);
    endtask

    // Stop bit ends just past the receiver's sample point so RX outruns TX
    task automatic overflow_burst ();
        logic [7:0] sent [n_long];
        int         i;
        int         j;
        echo_q.delete();
        for (i = 0; i < n_long; i++)
        begin
            rng_state = xorshift32(rng_state);
            sent[i]   = rng_state[7:0];
            send_byte(sent[i], 1'b0, half_bit + 8);
        end
        wait_drain();
        check_value("overflow LED pin", LED[5], 1'b0);
        check_value("first echoed byte", echo_at(0), sent[0]);
        if (echo_q.size() >= n_long)
        begin
            $display("All %0d bytes of the long burst came back, none was dropped", n_long);
            errors++;
        end
        j = 0;
        for (i = 0; i < echo_q.size(); i++)
        begin
            while (j < n_long && sent[j] != echo_q[i])
                j++;
            if (j == n_long)
            begin
                $display("Echoed byte %0d is out of order or was never sent", i);
                errors++;
                break;
            end
            j++;
        end
    endtask

    task automatic framing_error ();
        echo_q.delete();
        send_byte(8'hc3, 1'b1, clks_per_bit);
        wait_echoes(1);
        check_value("echo after framing error", echo_at(0), 8'hc3);
        check_value("framing LED pin", LED[4], 1'b0);
        apply_reset();
        check_value("LED after reset", LED, 6'h3f);
    endtask

    //------------------------------------------------------------

    initial
    begin : tx_monitor
        logic [7:0] data;
        int         i;
        forever
        begin
            @(negedge UART_TX);
            repeat (half_bit) @(posedge clk);
            if (UART_TX == 1'b0)
            begin
                for (i = 0; i < 8; i++)
                begin
                    repeat (clks_per_bit) @(posedge clk);
                    data[i] = UART_TX;
                end
                repeat (clks_per_bit) @(posedge clk);
                if (UART_TX !== 1'b1)
                begin
                    $display("Stop bit on UART_TX was not high");
                    errors++;
                end
                echo_q.push_back(data);
            end
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        KEY     <= '1;
        UART_RX <= 1'b1;

        check_idle_after_reset();
        echo_single_bytes();
        echo_with_case_swap();
        echo_burst();
        overflow_burst();
        framing_error();

        $display("Finished %0d checks with %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/board_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module board_top
(
    input  logic                CLK,
    input  logic [`W_KEY - 1:0] KEY,
    input  logic                UART_RX,
    output logic                UART_TX,
    output logic [`W_LED - 1:0] LED
);

    import serial_pkg::*;
    import board_pkg::*;

    wire clk = CLK;

    logic                                 reset;
    logic                                 case_swap;
    rx_byte_t                             rx_byte;
    logic                                 rx_strobe;
    rx_byte_t                             head;
    logic                                 empty;
    logic                                 pop;
    logic [$clog2(`FIFO_DEPTH + 1) - 1:0] fill;
    logic                                 overflow;
    logic                                 framing_seen;
    board_status_t                        status;

    // Keys read low when pressed
    assign reset     = ~KEY[`W_KEY - 1];
    assign case_swap = ~KEY[0];

    //------------------------------------------------------------

    uart_receiver i_receiver
    (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .rx        ( UART_RX   ),
        .rx_byte   ( rx_byte   ),
        .rx_strobe ( rx_strobe )
    );

    byte_fifo i_fifo
    (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .push      ( rx_strobe ),
        .push_data ( rx_byte   ),
        .pop       ( pop       ),
        .head      ( head      ),
        .empty     ( empty     ),
        .fill      ( fill      ),
        .overflow  ( overflow  )
    );

    uart_transmitter i_transmitter
    (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .empty     ( empty     ),
        .head      ( head      ),
        .case_swap ( case_swap ),
        .pop       ( pop       ),
        .tx        ( UART_TX   )
    );

    //------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
            framing_seen <= 1'b0;
        else if (rx_strobe && rx_byte.framing_err)
            framing_seen <= 1'b1;
    end

    always_comb
    begin
        status.overflow    = overflow;
        status.framing_err = framing_seen;
        status.fill        = fill[3:0];  // A full FIFO wraps to zero here
    end

    assign LED = ~status;  // LEDs are active low

endmodule

`default_nettype wire

//--- hdl/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module uart_transmitter
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 empty,
    input  serial_pkg::rx_byte_t head,
    input  logic                 case_swap,
    output logic                 pop,
    output logic                 tx
);

    import serial_pkg::*;

    localparam int clks_per_bit = `UART_CLKS_PER_BIT;
    localparam int w_cnt        = $clog2 (clks_per_bit);

    tx_state_t        state;
    logic [w_cnt-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             load;
    logic             bit_end;
    logic             next_bit;

    function automatic logic [7:0] swap_case (input logic [7:0] c);
        logic is_letter;
        is_letter = (c >= "A" && c <= "Z") || (c >= "a" && c <= "z");
        return is_letter ? (c ^ 8'h20) : c;  // Bit 5 selects the case
    endfunction

    assign load     = (state == TX_IDLE) && !empty;
    assign bit_end  = (state != TX_IDLE) && (clk_cnt == '0);
    assign next_bit = bit_end && (state == TX_START
                      || (state == TX_DATA && bit_idx != 3'd7));

    //------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (load)
            shift <= case_swap ? swap_case (head.data) : head.data;
        else if (next_bit)
            shift <= shift >> 1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            pop     <= 1'b0;
            tx      <= 1'b1;
        end
        else
        begin
            pop <= 1'b0;

            if (load)
            begin
                pop     <= 1'b1;  // Head leaves the FIFO on this pulse
                tx      <= 1'b0;  // Start bit
                clk_cnt <= w_cnt'(clks_per_bit - 1);
                state   <= TX_START;
            end
            else if (state != TX_IDLE && clk_cnt != '0)
                clk_cnt <= clk_cnt - 1'b1;
            else if (bit_end)
            begin
                clk_cnt <= w_cnt'(clks_per_bit - 1);

                case (state)
                    TX_START:
                    begin
                        tx      <= shift[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                    TX_DATA:
                    begin
                        if (bit_idx == 3'd7)
                        begin
                            tx    <= 1'b1;  // Stop bit
                            state <= TX_STOP;
                        end
                        else
                        begin
                            tx      <= shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                    default:
                        state <= TX_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module byte_fifo
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 push,
    input  serial_pkg::rx_byte_t                 push_data,
    input  logic                                 pop,
    output serial_pkg::rx_byte_t                 head,
    output logic                                 empty,
    output logic [$clog2(`FIFO_DEPTH + 1) - 1:0] fill,
    output logic                                 overflow
);

    import serial_pkg::*;

    localparam int depth  = `FIFO_DEPTH;
    localparam int w_ptr  = $clog2 (depth);
    localparam int w_fill = $clog2 (depth + 1);

    rx_byte_t         mem [depth];
    logic [w_ptr-1:0] wr_ptr;
    logic [w_ptr-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (fill == w_fill'(depth));
    assign empty   = (fill == '0);
    assign do_push = push & ~full;   // A push into a full buffer is lost
    assign do_pop  = pop  & ~empty;
    assign head    = mem[rd_ptr];

    //------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two

            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            if (do_push && !do_pop)
                fill <= fill + 1'b1;
            else if (do_pop && !do_push)
                fill <= fill - 1'b1;

            if (push && full)
                overflow <= 1'b1;  // Sticky until reset
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defines.svh"

module uart_receiver
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx,
    output serial_pkg::rx_byte_t rx_byte,
    output logic                 rx_strobe
);

    import serial_pkg::*;

    localparam int clks_per_bit = `UART_CLKS_PER_BIT;
    localparam int half_bit     = clks_per_bit / 2;
    localparam int w_cnt        = $clog2 (clks_per_bit);

    logic [2:0]       rx_pipe;     // Two sync stages plus the previous value
    logic             rx_bit;
    logic             start_edge;
    logic             busy;
    logic [w_cnt-1:0] clk_cnt;
    logic [3:0]       bit_idx;     // 0 start, 1 to 8 data, 9 stop
    logic             sample;
    logic [7:0]       shift;

    //------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
            rx_pipe <= '1;  // Line idles high
        else
            rx_pipe <= {rx_pipe[1:0], rx};
    end

    assign rx_bit     = rx_pipe[1];
    assign start_edge = rx_pipe[2] & ~rx_pipe[1];
    assign sample     = busy && (clk_cnt == '0);

    //------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end
        else
        begin
            rx_strobe <= 1'b0;

            if (!busy)
            begin
                if (start_edge)
                begin
                    busy    <= 1'b1;
                    clk_cnt <= w_cnt'(half_bit);  // Land in the middle of the start bit
                    bit_idx <= '0;
                end
            end
            else if (clk_cnt != '0)
                clk_cnt <= clk_cnt - 1'b1;
            else
            begin
                clk_cnt <= w_cnt'(clks_per_bit - 1);
                bit_idx <= bit_idx + 1'b1;

                if (bit_idx == 4'd0 && rx_bit)  // Glitch, not a real start bit
                    busy <= 1'b0;
                else if (bit_idx == 4'd9)
                begin
                    busy      <= 1'b0;
                    rx_strobe <= 1'b1;
                end
            end
        end
    end

    // Data path, LSB arrives first

    always_ff @(posedge clk)
    begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8)
            shift <= {rx_bit, shift[7:1]};

        if (sample && bit_idx == 4'd9)
        begin
            rx_byte.data        <= shift;
            rx_byte.framing_err <= ~rx_bit;
        end
    end

endmodule

`default_nettype wire

//--- hdl/board_pkg.sv
`default_nettype none

package board_pkg;

    // Packed from LED [5] down to LED [0]

    typedef struct packed
    {
        logic       overflow;     // Sticky, FIFO dropped a byte
        logic       framing_err;  // Sticky, a frame had a low stop bit
        logic [3:0] fill;         // Low bits of the FIFO level
    } board_status_t;

endpackage

`default_nettype wire

//--- hdl/serial_pkg.sv
`default_nettype none

package serial_pkg;

    //------------------------------------------------------------

    typedef struct packed
    {
        logic       framing_err;  // Stop bit sampled low
        logic [7:0] data;         // Character, bit 0 first on the line
    } rx_byte_t;

    //------------------------------------------------------------

    typedef enum logic [1:0]
    {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

//--- hdl/board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// Board clock and serial link

`define BOARD_CLK_MHZ       27
`define UART_BAUD           115200

// Truncated to a whole number of clocks, 234 at 27 MHz
`define UART_CLKS_PER_BIT   ((`BOARD_CLK_MHZ * 1000000) / `UART_BAUD)

// Byte buffer, keep it a power of two

`define FIFO_DEPTH          16

// Board I/O widths

`define W_KEY               2     // The last key is the reset
`define W_LED               6

`endif
